/* design/alPkg.sv */
// active list package: lane widths, entry payload layout and recovery states
package alPkg;

	// instructions written at the tail per cycle
	localparam int DISPATCH_WIDTH = 2;

	// entries retired from the head per cycle
	localparam int COMMIT_WIDTH = 2;

	// width of a retire count, 0 up to COMMIT_WIDTH
	localparam int COMMIT_CNT_W = $clog2(COMMIT_WIDTH + 1);

	localparam int PC_WIDTH = 32;

	// architectural register index
	localparam int LOG_REG_WIDTH = 5;

	// physical register index, 128 registers
	localparam int PHY_REG_WIDTH = 7;

	// static part of an instruction, written once at dispatch
	// and read back unchanged at retirement
	typedef struct packed {
		logic [PC_WIDTH-1:0]      pc;
		logic [LOG_REG_WIDTH-1:0] logDest;
		logic [PHY_REG_WIDTH-1:0] phyDest;
		// low for stores and branches, no rename map update
		logic                     hasDest;
	} alEntry;

	// recovery after a mispredicted branch leaves the head
	// idle while running normally, flush for the one cycle of the recover pulse
	typedef enum logic [1:0] {
		RCV_IDLE  = 2'd0,
		RCV_FLUSH = 2'd1
	} recoverState;

endpackage

/* design/alHeadIf.sv */
// head port bundle: head read addresses out to both tables, head contents back to commit
interface alHeadIf #(
	parameter int AL_DEPTH = 24
);
	import alPkg::*;

	localparam int IDX_W = $clog2(AL_DEPTH);

	// head pointer plus lane, already wrapped
	logic [COMMIT_WIDTH-1:0][IDX_W-1:0] headAddr;

	// payload at each head lane
	alEntry [COMMIT_WIDTH-1:0] headEntry;

	// completion status at each head lane
	logic [COMMIT_WIDTH-1:0] headExecuted;
	logic [COMMIT_WIDTH-1:0] headMispredict;

	// branch target, only lane 0 may trigger recovery
	logic [PC_WIDTH-1:0] headTarget;

	modport ptrSide (output headAddr);

	modport entrySide (input headAddr, output headEntry);

	modport statusSide (input headAddr, output headExecuted, headMispredict, headTarget);

	modport commitSide (input headEntry, headExecuted, headMispredict, headTarget);

endinterface

/* design/alEntryStore.sv */
// active list payload RAM: two write ports at the tail lanes, two read ports at the head lanes
module alEntryStore #(
	parameter int AL_DEPTH = 24,
	localparam int IDX_W = $clog2(AL_DEPTH)
) (
	input  logic                                          clk,
	input  logic [alPkg::DISPATCH_WIDTH-1:0]              wrEn_i,
	input  logic [alPkg::DISPATCH_WIDTH-1:0][IDX_W-1:0]   wrAddr_i,
	input  alPkg::alEntry [alPkg::DISPATCH_WIDTH-1:0]     wrEntry_i,
	alHeadIf.entrySide                                    head
);
	import alPkg::*;

	// one slot per in-flight instruction
	// contents are only meaningful while the status table marks them live
	alEntry entryRam [AL_DEPTH];

	// tail lanes always target distinct slots
	always_ff @(posedge clk)
	begin
		for (int l = 0; l < DISPATCH_WIDTH; l++)
		begin
			if (wrEn_i[l])
			begin
				entryRam[wrAddr_i[l]] <= wrEntry_i[l];
			end
		end
	end

	// asynchronous read at the head
	// same cycle as the pointer, so commit sees it without delay
	always_comb
	begin
		for (int l = 0; l < COMMIT_WIDTH; l++)
		begin
			head.headEntry[l] = entryRam[head.headAddr[l]];
		end
	end

endmodule

/* design/alStatusTable.sv */
// active list status: executed and mispredict bits per entry plus the branch target RAM
module alStatusTable #(
	parameter int AL_DEPTH = 24,
	localparam int IDX_W = $clog2(AL_DEPTH)
) (
	input  logic                                          clk,
	input  logic                                          reset,
	input  logic                                          flush_i,
	input  logic [alPkg::DISPATCH_WIDTH-1:0]              dispatchEn_i,
	input  logic [alPkg::DISPATCH_WIDTH-1:0][IDX_W-1:0]   dispatchAddr_i,
	input  logic                                          complete_i,
	input  logic [IDX_W-1:0]                              completeId_i,
	input  logic                                          mispredict_i,
	input  logic [alPkg::PC_WIDTH-1:0]                    targetPc_i,
	input  logic [alPkg::COMMIT_WIDTH-1:0]                retireMask_i,
	alHeadIf.statusSide                                   head
);
	import alPkg::*;

	// one bit per slot
	logic [AL_DEPTH-1:0] executed;
	logic [AL_DEPTH-1:0] mispred;

	// resolved target of each completed instruction
	logic [PC_WIDTH-1:0] targetRam [AL_DEPTH];

	// later statements win on the same slot
	// retire clear, then dispatch clear, then completion set
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			executed <= '0;
			mispred  <= '0;
		end
		else if (flush_i)
		begin
			// everything younger than the branch is squashed,
			// including a completion arriving this cycle
			executed <= '0;
			mispred  <= '0;
		end
		else
		begin
			for (int l = 0; l < COMMIT_WIDTH; l++)
			begin
				if (retireMask_i[l])
				begin
					executed[head.headAddr[l]] <= 1'b0;
				end
			end
			// fresh slot starts not executed
			for (int l = 0; l < DISPATCH_WIDTH; l++)
			begin
				if (dispatchEn_i[l])
				begin
					executed[dispatchAddr_i[l]] <= 1'b0;
					mispred[dispatchAddr_i[l]]  <= 1'b0;
				end
			end
			if (complete_i)
			begin
				executed[completeId_i] <= 1'b1;
				mispred[completeId_i]  <= mispredict_i;
			end
		end
	end

	// target only read when the mispredict bit is set
	always_ff @(posedge clk)
	begin
		if (complete_i)
		begin
			targetRam[completeId_i] <= targetPc_i;
		end
	end

	always_comb
	begin
		for (int l = 0; l < COMMIT_WIDTH; l++)
		begin
			head.headExecuted[l]   = executed[head.headAddr[l]];
			head.headMispredict[l] = mispred[head.headAddr[l]];
		end
		head.headTarget = targetRam[head.headAddr[0]];
	end

endmodule

/* design/alCommitLogic.sv */
// commit unit: in-order retire selection over the two head lanes, retire outputs and recovery trigger
module alCommitLogic #(
	parameter int AL_DEPTH = 24,
	localparam int IDX_W = $clog2(AL_DEPTH),
	localparam int CNT_W = IDX_W + 1
) (
	alHeadIf.commitSide                                       head,
	input  logic [CNT_W-1:0]                                  alCount_i,
	input  logic                                              commitStall_i,
	input  logic                                              recovering_i,
	output logic [alPkg::COMMIT_WIDTH-1:0]                    retireMask_o,
	output logic [alPkg::COMMIT_CNT_W-1:0]                    totalCommit_o,
	output logic                                              mispredRetire_o,
	output logic [alPkg::PC_WIDTH-1:0]                        retireTarget_o,
	output logic [alPkg::COMMIT_WIDTH-1:0]                    commitValid_o,
	output logic [alPkg::COMMIT_WIDTH-1:0][alPkg::LOG_REG_WIDTH-1:0] commitLogDest_o,
	output logic [alPkg::COMMIT_WIDTH-1:0][alPkg::PHY_REG_WIDTH-1:0] commitPhyDest_o,
	output logic [alPkg::COMMIT_WIDTH-1:0]                    commitHasDest_o
);
	import alPkg::*;

	// store buffer full or a recovery in progress freezes the head
	logic retireAllowed;

	assign retireAllowed = ~commitStall_i & ~recovering_i;

	// lane logic written for two lanes
	always_comb
	begin
		// head retires once executed, mispredicted or not
		retireMask_o[0] = retireAllowed
			& (alCount_i > CNT_W'(0))
			& head.headExecuted[0];

		// second lane needs the first, and neither may be a mispredict
		// a mispredicted branch only ever leaves through lane 0,
		// so it waits one cycle to reach the head
		retireMask_o[1] = retireMask_o[0]
			& (alCount_i > CNT_W'(1))
			& head.headExecuted[1]
			& ~head.headMispredict[0]
			& ~head.headMispredict[1];
	end

	// count of retiring lanes, mask is always contiguous from lane 0
	always_comb
	begin
		totalCommit_o = '0;
		for (int l = 0; l < COMMIT_WIDTH; l++)
		begin
			totalCommit_o = totalCommit_o + COMMIT_CNT_W'(retireMask_o[l]);
		end
	end

	// recovery trigger for the top
	assign mispredRetire_o = retireMask_o[0] & head.headMispredict[0];
	assign retireTarget_o  = head.headTarget;

	// rename map update per lane
	always_comb
	begin
		for (int l = 0; l < COMMIT_WIDTH; l++)
		begin
			commitValid_o[l]   = retireMask_o[l];
			commitLogDest_o[l] = head.headEntry[l].logDest;
			commitPhyDest_o[l] = head.headEntry[l].phyDest;
			// only qualified with retire, dest fields are free running
			commitHasDest_o[l] = head.headEntry[l].hasDest & retireMask_o[l];
		end
	end

endmodule

/* design/activeList.sv */
// active list top: circular reorder buffer pointers, occupancy count and branch recovery
module activeList #(
	parameter int AL_DEPTH = 24,
	localparam int IDX_W = $clog2(AL_DEPTH),
	localparam int CNT_W = IDX_W + 1
) (
	input  logic                                              clk,
	input  logic                                              reset,
	input  logic [alPkg::DISPATCH_WIDTH-1:0]                  dispatchValid_i,
	input  alPkg::alEntry [alPkg::DISPATCH_WIDTH-1:0]         dispatchEntry_i,
	input  logic                                              complete_i,
	input  logic [IDX_W-1:0]                                  completeId_i,
	input  logic                                              mispredict_i,
	input  logic [alPkg::PC_WIDTH-1:0]                        targetPc_i,
	input  logic                                              commitStall_i,
	output logic                                              dispatchReady_o,
	output logic [alPkg::DISPATCH_WIDTH-1:0][IDX_W-1:0]       alId_o,
	output logic [alPkg::COMMIT_WIDTH-1:0]                    commitValid_o,
	output logic [alPkg::COMMIT_WIDTH-1:0][alPkg::LOG_REG_WIDTH-1:0] commitLogDest_o,
	output logic [alPkg::COMMIT_WIDTH-1:0][alPkg::PHY_REG_WIDTH-1:0] commitPhyDest_o,
	output logic [alPkg::COMMIT_WIDTH-1:0]                    commitHasDest_o,
	output logic [alPkg::COMMIT_CNT_W-1:0]                    totalCommit_o,
	output logic [CNT_W-1:0]                                  alCount_o,
	output logic [IDX_W-1:0]                                  alHead_o,
	output logic [IDX_W-1:0]                                  alTail_o,
	output logic                                              recoverFlag_o,
	output logic [alPkg::PC_WIDTH-1:0]                        recoverPc_o
);
	import alPkg::*;

	logic [IDX_W-1:0] headPtr;
	logic [IDX_W-1:0] tailPtr;
	logic [CNT_W-1:0] alCount;
	recoverState      rcvState;
	logic [PC_WIDTH-1:0] recoverPc;

	logic [DISPATCH_WIDTH-1:0] dispatchEn;
	logic [CNT_W-1:0]          dispCount;
	logic                      mispredRetire;
	logic [PC_WIDTH-1:0]       retireTarget;
	logic [COMMIT_WIDTH-1:0]   retireMask;

	// depth need not be a power of two, so wrap by compare and subtract
	function automatic logic [IDX_W-1:0] wrapAdd(input logic [IDX_W-1:0] ptr,
		input logic [CNT_W-1:0] inc);
		logic [CNT_W-1:0] sum;
		sum = {1'b0, ptr} + inc;
		if (sum >= CNT_W'(AL_DEPTH))
		begin
			sum = sum - CNT_W'(AL_DEPTH);
		end
		return sum[IDX_W-1:0];
	endfunction

	alHeadIf #(.AL_DEPTH(AL_DEPTH)) headIf ();

	// at least two free slots and no recovery pending
	assign dispatchReady_o = (alCount <= CNT_W'(AL_DEPTH - DISPATCH_WIDTH))
		& (rcvState == RCV_IDLE);
	assign recoverFlag_o = (rcvState == RCV_FLUSH);
	assign recoverPc_o   = recoverPc;

	// producer only drives valids while ready, gate anyway to protect the pointers
	assign dispatchEn = dispatchValid_i & {DISPATCH_WIDTH{dispatchReady_o}};

	// per lane IDs from the tail, per lane read addresses from the head
	always_comb
	begin
		dispCount = '0;
		for (int l = 0; l < DISPATCH_WIDTH; l++)
		begin
			alId_o[l] = wrapAdd(tailPtr, CNT_W'(l));
			dispCount = dispCount + CNT_W'(dispatchEn[l]);
		end
		for (int l = 0; l < COMMIT_WIDTH; l++)
		begin
			headIf.headAddr[l] = wrapAdd(headPtr, CNT_W'(l));
		end
	end

	alEntryStore #(.AL_DEPTH(AL_DEPTH)) i_alEntryStore (
		.clk       (clk),
		.wrEn_i    (dispatchEn),
		.wrAddr_i  (alId_o),
		.wrEntry_i (dispatchEntry_i),
		.head      (headIf.entrySide)
	);

	alStatusTable #(.AL_DEPTH(AL_DEPTH)) i_alStatusTable (
		.clk            (clk),
		.reset          (reset),
		.flush_i        (mispredRetire),
		.dispatchEn_i   (dispatchEn),
		.dispatchAddr_i (alId_o),
		.complete_i     (complete_i),
		.completeId_i   (completeId_i),
		.mispredict_i   (mispredict_i),
		.targetPc_i     (targetPc_i),
		.retireMask_i   (retireMask),
		.head           (headIf.statusSide)
	);

	alCommitLogic #(.AL_DEPTH(AL_DEPTH)) i_alCommitLogic (
		.head            (headIf.commitSide),
		.alCount_i       (alCount),
		.commitStall_i   (commitStall_i),
		.recovering_i    (recoverFlag_o),
		.retireMask_o    (retireMask),
		.totalCommit_o   (totalCommit_o),
		.mispredRetire_o (mispredRetire),
		.retireTarget_o  (retireTarget),
		.commitValid_o   (commitValid_o),
		.commitLogDest_o (commitLogDest_o),
		.commitPhyDest_o (commitPhyDest_o),
		.commitHasDest_o (commitHasDest_o)
	);

	// pointers and count
	// a mispredicted retire empties the list, dispatches that cycle are dropped
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			headPtr <= '0;
			tailPtr <= '0;
			alCount <= '0;
		end
		else if (mispredRetire)
		begin
			headPtr <= '0;
			tailPtr <= '0;
			alCount <= '0;
		end
		else
		begin
			headPtr <= wrapAdd(headPtr, CNT_W'(totalCommit_o));
			tailPtr <= wrapAdd(tailPtr, dispCount);
			alCount <= alCount + dispCount - CNT_W'(totalCommit_o);
		end
	end

	// recovery FSM, flush state lasts exactly one cycle
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rcvState <= RCV_IDLE;
		end
		else if (mispredRetire)
		begin
			rcvState <= RCV_FLUSH;
		end
		else
		begin
			rcvState <= RCV_IDLE;
		end
	end

	// branch target captured as the branch leaves the head
	always_ff @(posedge clk)
	begin
		if (mispredRetire)
		begin
			recoverPc <= retireTarget;
		end
	end

	assign alCount_o = alCount;
	assign alHead_o  = headPtr;
	assign alTail_o  = tailPtr;

endmodule

/* verif/activeList_chk.sv */
// active list protocol checker: dispatch handshake, occupancy bound, recovery pulse, retire order
module activeListChk #(
	parameter int AL_DEPTH = 24,
	localparam int CNT_W = $clog2(AL_DEPTH) + 1
) (
	input logic                              clk,
	input logic                              reset,
	input logic [alPkg::DISPATCH_WIDTH-1:0]  dispatchValid_i,
	input logic                              dispatchReady_i,
	input logic [CNT_W-1:0]                  alCount_i,
	input logic                              recoverFlag_i,
	input logic [alPkg::COMMIT_WIDTH-1:0]    commitValid_i
);
	timeunit 1ns;
	timeprecision 100ps;

	// producer holds valids low while the list is busy
	noDispatchBusy: assert property (@(posedge clk) disable iff (reset)
		!dispatchReady_i |-> (dispatchValid_i == '0))
		else $error("dispatch valid while not ready");

	countBound: assert property (@(posedge clk) disable iff (reset)
		alCount_i <= CNT_W'(AL_DEPTH))
		else $error("occupancy above depth");

	// recover pulse is a single cycle
	recoverPulse: assert property (@(posedge clk) disable iff (reset)
		recoverFlag_i |=> !recoverFlag_i)
		else $error("recover flag held longer than one cycle");

	laneOrder: assert property (@(posedge clk) disable iff (reset)
		commitValid_i[1] |-> commitValid_i[0])
		else $error("lane 1 retired without lane 0");

endmodule

bind activeList activeListChk #(.AL_DEPTH(AL_DEPTH)) i_activeListChk (
	.clk             (clk),
	.reset           (reset),
	.dispatchValid_i (dispatchValid_i),
	.dispatchReady_i (dispatchReady_o),
	.alCount_i       (alCount_o),
	.recoverFlag_i   (recoverFlag_o),
	.commitValid_i   (commitValid_o)
);

/* verif/activeListTb.sv */
// active list testbench: LFSR stimulus, queue reference model and per-cycle output checks
module activeListTb;
	timeunit 1ns;
	timeprecision 100ps;
	import alPkg::*;

	localparam int AL_DEPTH = 24;
	localparam int IDX_W = $clog2(AL_DEPTH);
	localparam int CNT_W = IDX_W + 1;
	localparam int RUN_CYCLES = 3000;
	localparam int DRAIN_LIMIT = 200;

	logic clk;
	logic reset;
	logic [DISPATCH_WIDTH-1:0] dispatchValid_i;
	alEntry [DISPATCH_WIDTH-1:0] dispatchEntry_i;
	logic complete_i;
	logic [IDX_W-1:0] completeId_i;
	logic mispredict_i;
	logic [PC_WIDTH-1:0] targetPc_i;
	logic commitStall_i;
	logic dispatchReady_o;
	logic [DISPATCH_WIDTH-1:0][IDX_W-1:0] alId_o;
	logic [COMMIT_WIDTH-1:0] commitValid_o;
	logic [COMMIT_WIDTH-1:0][LOG_REG_WIDTH-1:0] commitLogDest_o;
	logic [COMMIT_WIDTH-1:0][PHY_REG_WIDTH-1:0] commitPhyDest_o;
	logic [COMMIT_WIDTH-1:0] commitHasDest_o;
	logic [COMMIT_CNT_W-1:0] totalCommit_o;
	logic [CNT_W-1:0] alCount_o;
	logic [IDX_W-1:0] alHead_o;
	logic [IDX_W-1:0] alTail_o;
	logic recoverFlag_o;
	logic [PC_WIDTH-1:0] recoverPc_o;

	// one in-flight instruction as the model sees it
	typedef struct packed {
		logic [IDX_W-1:0] id;
		alEntry ent;
		logic exec;
		logic misp;
		logic [PC_WIDTH-1:0] target;
	} modelEntry;

	// oldest entry at the front
	modelEntry mq[$];
	int mHead;
	int mTail;
	int maxCount;
	int recoveries;
	logic mRecover;
	logic [PC_WIDTH-1:0] mRecoverPc;
	logic [31:0] lfsr;

	activeList #(.AL_DEPTH(AL_DEPTH)) i_activeList (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// fibonacci LFSR, taps 32 22 2 1
	function automatic logic nextBit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], nextBit()};
		end
		return v;
	endfunction

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic checkVal(input string name, input logic [63:0] expVal,
		input logic [63:0] actVal);
		if (expVal !== actVal)
		begin
			stopRun($sformatf("ERR %0t %s expected %0h actual %0h", $time, name, expVal, actVal));
		end
	endtask

	// one clock: drive at the falling edge, check, then advance the model past the rising edge
	task automatic runCycle(input logic fill, input logic drain);
		logic [DISPATCH_WIDTH-1:0] valid;
		logic [COMMIT_WIDTH-1:0] retire;
		logic expReady;
		logic expHasDest;
		int pend[$];
		int pick;
		modelEntry ne;
		@(negedge clk);
		pick = 0;
		valid = '0;
		expReady = (mq.size() <= AL_DEPTH - DISPATCH_WIDTH) && !mRecover;
		if (expReady && !drain)
		begin
			if (fill)
			begin
				// pairs only from an even count, so the list ends exactly full
				valid = (mq.size() % 2 == 0) ? 2'b11 : 2'b01;
			end
			else
			begin
				valid[0] = nextBit();
				valid[1] = valid[0] & nextBit();
			end
		end
		dispatchValid_i = valid;
		dispatchEntry_i = '0;
		for (int l = 0; l < DISPATCH_WIDTH; l++)
		begin
			if (valid[l])
			begin
				dispatchEntry_i[l].pc = randBits(PC_WIDTH);
				dispatchEntry_i[l].logDest = LOG_REG_WIDTH'(randBits(LOG_REG_WIDTH));
				dispatchEntry_i[l].phyDest = PHY_REG_WIDTH'(randBits(PHY_REG_WIDTH));
				dispatchEntry_i[l].hasDest = nextBit();
			end
		end
		// completion picks any outstanding entry not yet executed
		for (int i = 0; i < mq.size(); i++)
		begin
			if (!mq[i].exec)
			begin
				pend.push_back(i);
			end
		end
		complete_i = 1'b0;
		mispredict_i = 1'b0;
		if (pend.size() > 0 && randBits(2) != '0)
		begin
			pick = int'(randBits(5)) % pend.size();
			complete_i = 1'b1;
			completeId_i = mq[pend[pick]].id;
			mispredict_i = (randBits(5) == '0);
			targetPc_i = randBits(PC_WIDTH);
		end
		commitStall_i = fill ? 1'b1 : (drain ? 1'b0 : (randBits(2) == '0));
		#1;
		// in-order retire over the two head lanes
		retire = '0;
		if (!commitStall_i && !mRecover && mq.size() > 0)
		begin
			retire[0] = mq[0].exec;
			if (retire[0] && mq.size() > 1)
			begin
				retire[1] = mq[1].exec & ~mq[0].misp & ~mq[1].misp;
			end
		end
		checkVal("dispatchReady_o", 64'(expReady), 64'(dispatchReady_o));
		checkVal("alCount_o", 64'(mq.size()), 64'(alCount_o));
		checkVal("alHead_o", 64'(mHead), 64'(alHead_o));
		checkVal("alTail_o", 64'(mTail), 64'(alTail_o));
		checkVal("recoverFlag_o", 64'(mRecover), 64'(recoverFlag_o));
		if (mRecover)
		begin
			checkVal("recoverPc_o", 64'(mRecoverPc), 64'(recoverPc_o));
		end
		checkVal("commitValid_o", 64'(retire), 64'(commitValid_o));
		checkVal("totalCommit_o", 64'(retire[0]) + 64'(retire[1]), 64'(totalCommit_o));
		for (int l = 0; l < DISPATCH_WIDTH; l++)
		begin
			checkVal("alId_o", 64'((mTail + l) % AL_DEPTH), 64'(alId_o[l]));
		end
		for (int l = 0; l < COMMIT_WIDTH; l++)
		begin
			if (retire[l])
			begin
				checkVal("commitLogDest_o", 64'(mq[l].ent.logDest), 64'(commitLogDest_o[l]));
				checkVal("commitPhyDest_o", 64'(mq[l].ent.phyDest), 64'(commitPhyDest_o[l]));
			end
			expHasDest = retire[l] ? mq[l].ent.hasDest : 1'b0;
			checkVal("commitHasDest_o", 64'(expHasDest), 64'(commitHasDest_o[l]));
		end
		if (retire[0] && mq[0].misp)
		begin
			// branch leaves the head, younger work and this cycle's dispatch are squashed
			mRecoverPc = mq[0].target;
			mRecover = 1'b1;
			mq.delete();
			mHead = 0;
			mTail = 0;
			recoveries++;
		end
		else
		begin
			mRecover = 1'b0;
			if (complete_i)
			begin
				ne = mq[pend[pick]];
				ne.exec = 1'b1;
				ne.misp = mispredict_i;
				ne.target = targetPc_i;
				mq[pend[pick]] = ne;
			end
			for (int l = 0; l < COMMIT_WIDTH; l++)
			begin
				if (retire[l])
				begin
					void'(mq.pop_front());
					mHead = (mHead + 1) % AL_DEPTH;
				end
			end
			for (int l = 0; l < DISPATCH_WIDTH; l++)
			begin
				if (valid[l])
				begin
					ne = '0;
					ne.id = IDX_W'(mTail);
					ne.ent = dispatchEntry_i[l];
					mq.push_back(ne);
					mTail = (mTail + 1) % AL_DEPTH;
				end
			end
		end
		if (mq.size() > maxCount)
		begin
			maxCount = mq.size();
		end
	endtask

	initial
	begin
		int waited;
		lfsr = 32'd95032;
		mHead = 0;
		mTail = 0;
		maxCount = 0;
		recoveries = 0;
		mRecover = 1'b0;
		mRecoverPc = '0;
		reset = 1'b1;
		dispatchValid_i = '0;
		dispatchEntry_i = '0;
		complete_i = 1'b0;
		completeId_i = '0;
		mispredict_i = 1'b0;
		targetPc_i = '0;
		commitStall_i = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		#1;
		checkVal("alCount_o", 64'(0), 64'(alCount_o));
		checkVal("dispatchReady_o", 64'(1), 64'(dispatchReady_o));
		checkVal("commitValid_o", 64'(0), 64'(commitValid_o));
		checkVal("recoverFlag_o", 64'(0), 64'(recoverFlag_o));
		// random traffic, with a long stall window every 500 cycles to fill the list
		for (int cyc = 0; cyc < RUN_CYCLES; cyc++)
		begin
			runCycle(cyc % 500 >= 440, 1'b0);
		end
		// no new work, stall released, everything outstanding must leave
		waited = 0;
		while (mq.size() != 0 || mRecover)
		begin
			if (waited == DRAIN_LIMIT)
			begin
				stopRun("list did not drain after dispatch stopped and stall was released");
			end
			else
			begin
				runCycle(1'b0, 1'b1);
				waited++;
			end
		end
		if (maxCount < AL_DEPTH || recoveries == 0)
		begin
			stopRun($sformatf("list never filled or never recovered: max %0d, recoveries %0d",
				maxCount, recoveries));
		end
		else
		begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

/* sources.f */
design/alPkg.sv
design/alHeadIf.sv
design/alEntryStore.sv
design/alStatusTable.sv
design/alCommitLogic.sv
design/activeList.sv
verif/activeList_chk.sv
verif/activeListTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module activeListTb -o simActiveList

if ./obj_dir/simActiveList | tee /dev/stderr | grep "Simulation PASSED" > /dev/null
then
	echo "run.sh: test passed"
	exit 0
fi
echo "run.sh: test failed"
exit 1
